//--- list.f
+incdir+.
camera_pkg.sv
crop_window_regs.sv
bayer_crop.sv
bayer_binning.sv
rgb_metering.sv
camera_frontend.sv
camera_tb_clock.sv
camera_asserts.sv
camera_tb.sv

//--- camera_tb.sv
// Camera front end testbench
`timescale 1ns/1ps
`default_nettype none

`include "camera_defs.svh"

module camera_tb import camera_pkg::*; ();

    logic          mipi_byte_clock;
    logic          mipi_byte_reset_n;
    bayer_stream_t bayer_in;
    logic          cfg_write;
    cfg_addr_t     cfg_addr;
    coord_t        cfg_data;
    rgb_stream_t   rgb_out;
    meter_result_t metering;
    logic          metering_ready;

    logic [31:0]   lcg_state = 32'h84383dab;
    raw_pixel_t    frame_pix [64][64];      // Current frame, row then column
    int            window [4];              // Written window, indexed like cfg_addr
    rgb_stream_t   expected_pixels [$];
    meter_result_t expected_results [$];
    int            errors = 0;
    int            frames_sent = 0;
    int            ready_count = 0;
    int            since_fall = 100;        // Cycles since input frame valid fell
    logic          prev_frame_valid = 1'b0;
    logic [1:0]    frame_valid_history = 2'b00;  // Input frame valid, last two cycles

    camera_tb_clock clock_gen (
        .clock_o   (mipi_byte_clock),
        .reset_n_o (mipi_byte_reset_n)
    );

    camera_frontend UUT (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .bayer_i           (bayer_in),
        .cfg_write_i       (cfg_write),
        .cfg_addr_i        (cfg_addr),
        .cfg_data_i        (cfg_data),
        .rgb_o             (rgb_out),
        .metering_o        (metering),
        .metering_ready_o  (metering_ready)
    );

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("FAIL %0t %s expected %0d got %0d", $time, name, expected, actual);
        end
    endtask

    task automatic drive_cycle(input logic fv, input logic lv, input raw_pixel_t data);
        @(posedge mipi_byte_clock);
        #1;
        bayer_in.frame_valid = fv;
        bayer_in.line_valid = lv;
        bayer_in.data = data;
        cfg_write = 1'b0;
    endtask

    task automatic drive_idle(input int cycles);
        repeat (cycles) drive_cycle(1'b0, 1'b0, '0);
    endtask

    task automatic write_window(input cfg_addr_t addr, input int value, input logic fv);
        @(posedge mipi_byte_clock);
        #1;
        bayer_in.frame_valid = fv;
        bayer_in.line_valid = 1'b0;
        cfg_write = 1'b1;
        cfg_addr = addr;
        cfg_data = coord_t'(value);
        window[addr] = value & ~1;          // Registers keep quads aligned
    endtask

    // Crop, bin and meter the stored frame with the written window
    task automatic predict_frame(input int width, input int height);
        int            xs;
        int            xe;
        int            ys;
        int            ye;
        int            red_sum;
        int            green_sum;
        int            blue_sum;
        rgb_stream_t   pix;
        meter_result_t result;
        xs = window[0];
        xe = (window[1] < width) ? window[1] : width;
        ys = window[2];
        ye = (window[3] < height) ? window[3] : height;
        red_sum = 0;
        green_sum = 0;
        blue_sum = 0;
        for (int r = 0; ys + 2 * r + 1 < ye; r++) begin
            for (int c = 0; xs + 2 * c + 1 < xe; c++) begin
                pix = '0;
                pix.red = frame_pix[ys + 2 * r][xs + 2 * c];
                pix.green = raw_pixel_t'((int'(frame_pix[ys + 2 * r][xs + 2 * c + 1]) +
                                          int'(frame_pix[ys + 2 * r + 1][xs + 2 * c])) >> 1);
                pix.blue = frame_pix[ys + 2 * r + 1][xs + 2 * c + 1];
                expected_pixels.push_back(pix);
                if (r < `METER_SIZE && c < `METER_SIZE) begin
                    red_sum += pix.red;
                    green_sum += pix.green;
                    blue_sum += pix.blue;
                end
            end
        end
        result.red = meter_value_t'((red_sum >> (2 * `METER_LOG2)) >> (`PIXEL_BITS - 8));
        result.green = meter_value_t'((green_sum >> (2 * `METER_LOG2)) >> (`PIXEL_BITS - 8));
        result.blue = meter_value_t'((blue_sum >> (2 * `METER_LOG2)) >> (`PIXEL_BITS - 8));
        expected_results.push_back(result);
    endtask

    task automatic send_frame(input int width, input int height, input int line_gap,
                              input int frame_gap, input logic mid_write,
                              input cfg_addr_t addr, input int value);
        for (int r = 0; r < height; r++) begin
            for (int c = 0; c < width; c++) begin
                frame_pix[r][c] = raw_pixel_t'(next_random() >> 16);
            end
        end
        predict_frame(width, height);
        drive_cycle(1'b1, 1'b0, '0);
        drive_cycle(1'b1, 1'b0, '0);
        for (int r = 0; r < height; r++) begin
            for (int c = 0; c < width; c++) begin
                drive_cycle(1'b1, 1'b1, frame_pix[r][c]);
            end
            for (int g = 0; g < line_gap; g++) begin
                if (mid_write && r == height / 2 && g == 0) begin
                    write_window(addr, value, 1'b1);     // Lands inside the frame
                end else begin
                    drive_cycle(1'b1, 1'b0, '0);
                end
            end
        end
        drive_idle(frame_gap);
        frames_sent++;
    endtask

    task automatic wait_for_results();
        int cycles;
        cycles = 0;
        while ((ready_count < frames_sent || expected_pixels.size() != 0) && cycles < 300) begin
            @(negedge mipi_byte_clock);
            cycles++;
        end
        if (ready_count < frames_sent || expected_pixels.size() != 0) begin
            errors++;
            $display("Timed out at %0t waiting for RGB pixels or metering result", $time);
        end
    endtask

    always @(negedge mipi_byte_clock) begin : monitor
        rgb_stream_t   exp_pix;
        meter_result_t exp_result;
        if (mipi_byte_reset_n) begin
            if (prev_frame_valid && !bayer_in.frame_valid) begin
                since_fall = 0;
            end else if (since_fall < 100) begin
                since_fall++;
            end
            prev_frame_valid = bayer_in.frame_valid;
            // Two cycles from input to RGB output
            compare_value("rgb_o.frame_valid", frame_valid_history[1], rgb_out.frame_valid);
            frame_valid_history = {frame_valid_history[0], bayer_in.frame_valid};
            if (rgb_out.valid) begin
                if (expected_pixels.size() == 0) begin
                    errors++;
                    $display("Unexpected RGB pixel at %0t", $time);
                end else begin
                    exp_pix = expected_pixels.pop_front();
                    compare_value("rgb_o.red", exp_pix.red, rgb_out.red);
                    compare_value("rgb_o.green", exp_pix.green, rgb_out.green);
                    compare_value("rgb_o.blue", exp_pix.blue, rgb_out.blue);
                end
            end
            if (metering_ready) begin
                ready_count++;
                compare_value("metering_ready_o latency", 4, since_fall);
                if (expected_results.size() == 0) begin
                    errors++;
                    $display("Metering result at %0t with no frame outstanding", $time);
                end else begin
                    exp_result = expected_results.pop_front();
                    compare_value("metering_o.red", exp_result.red, metering.red);
                    compare_value("metering_o.green", exp_result.green, metering.green);
                    compare_value("metering_o.blue", exp_result.blue, metering.blue);
                end
            end
        end
    end

    initial begin
        int width;
        int height;
        int line_gap;
        int frame_gap;
        bayer_in = '0;
        cfg_write = 1'b0;
        cfg_addr = '0;
        cfg_data = '0;
        window = '{`RESET_X_START, `RESET_X_END, `RESET_Y_START, `RESET_Y_END};
        for (int i = 0; i < 50 && mipi_byte_reset_n !== 1'b1; i++) begin
            @(posedge mipi_byte_clock);
        end
        if (mipi_byte_reset_n !== 1'b1) begin
            errors++;
            $display("Reset was never released");
        end
        drive_idle(4);
        // Default window gives 16x8 binned pixels
        send_frame(40, 24, 2, 4, 1'b0, '0, 0);
        wait_for_results();
        // Odd values are forced even
        write_window(CFG_X_START, 5, 1'b0);
        write_window(CFG_X_END, 37, 1'b0);
        write_window(CFG_Y_START, 3, 1'b0);
        write_window(CFG_Y_END, 21, 1'b0);
        drive_idle(4);
        send_frame(40, 24, 3, 4, 1'b0, '0, 0);
        wait_for_results();
        // Write inside a frame only reaches the next one
        send_frame(40, 24, 2, 4, 1'b1, CFG_X_START, 9);
        send_frame(40, 24, 2, 6, 1'b0, '0, 0);
        wait_for_results();
        for (int f = 0; f < 6; f++) begin
            width = 36 + 2 * int'((next_random() >> 8) % 15);
            height = 20 + 2 * int'((next_random() >> 8) % 6);
            line_gap = 2 + int'((next_random() >> 8) % 4);
            frame_gap = 4 + int'((next_random() >> 8) % 4);
            send_frame(width, height, line_gap, frame_gap, 1'b0, '0, 0);
        end
        wait_for_results();
        drive_idle(20);
        compare_value("metering_ready_o pulses", frames_sent, ready_count);
        errors += UUT.stream_checks.failures;
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- camera_asserts.sv
// Front end stream assertions
`timescale 1ns/1ps
`default_nettype none

module camera_asserts import camera_pkg::*; (
    input logic        mipi_byte_clock,
    input logic        mipi_byte_reset_n,
    input rgb_stream_t rgb_i,
    input logic        metering_ready_i
);

    int failures = 0;                       // Failed assertion count

    quiet_in_reset: assert property (@(posedge mipi_byte_clock)
        !mipi_byte_reset_n |=> (!rgb_i.valid && !metering_ready_i))
        else begin
            failures++;
            $error("RGB valid or metering ready high during or just after reset");
        end

    valid_in_frame: assert property (@(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
        rgb_i.valid |-> rgb_i.frame_valid)
        else begin
            failures++;
            $error("RGB valid outside of frame valid");
        end

    ready_single_pulse: assert property (@(posedge mipi_byte_clock)
        disable iff (!mipi_byte_reset_n) metering_ready_i |=> !metering_ready_i)
        else begin
            failures++;
            $error("Metering ready held longer than one cycle");
        end

endmodule

bind camera_frontend camera_asserts stream_checks (
    .mipi_byte_clock   (mipi_byte_clock),
    .mipi_byte_reset_n (mipi_byte_reset_n),
    .rgb_i             (rgb_o),
    .metering_ready_i  (metering_ready_o)
);

`default_nettype wire

//--- camera_tb_clock.sv
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module camera_tb_clock (
    output logic clock_o,
    output logic reset_n_o
);

    initial begin
        clock_o = 1'b0;
        forever #5 clock_o = ~clock_o;      // 10 ns period
    end

    initial begin
        reset_n_o = 1'b0;
        repeat (5) @(posedge clock_o);
        @(negedge clock_o);
        reset_n_o = 1'b1;                   // Release away from the active edge
    end

endmodule

`default_nettype wire

//--- camera_frontend.sv
// Camera byte clock front end
`timescale 1ns/1ps
`default_nettype none

module camera_frontend import camera_pkg::*; (
    input  logic          mipi_byte_clock,
    input  logic          mipi_byte_reset_n,
    input  bayer_stream_t bayer_i,
    input  logic          cfg_write_i,
    input  cfg_addr_t     cfg_addr_i,
    input  coord_t        cfg_data_i,
    output rgb_stream_t   rgb_o,
    output meter_result_t metering_o,
    output logic          metering_ready_o
);

    crop_window_t  crop_window;
    bayer_stream_t cropped;
    rgb_stream_t   binned;

    crop_window_regs crop_window_regs (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .cfg_write_i       (cfg_write_i),
        .cfg_addr_i        (cfg_addr_i),
        .cfg_data_i        (cfg_data_i),
        .frame_active_i    (bayer_i.frame_valid),  // Hold window during a frame
        .window_o          (crop_window)
    );

    bayer_crop pan_crop (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .raw_i             (bayer_i),
        .window_i          (crop_window),
        .cropped_o         (cropped)
    );

    bayer_binning binning (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .cropped_i         (cropped),
        .rgb_o             (binned)
    );

    rgb_metering metering (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .rgb_i             (binned),
        .result_o          (metering_o),
        .ready_o           (metering_ready_o)
    );

    assign rgb_o = binned;

endmodule

`default_nettype wire

//--- rgb_metering.sv
// RGB average metering
`timescale 1ns/1ps
`default_nettype none

`include "camera_defs.svh"

module rgb_metering import camera_pkg::*; (
    input  logic          mipi_byte_clock,
    input  logic          mipi_byte_reset_n,
    input  rgb_stream_t   rgb_i,
    output meter_result_t result_o,
    output logic          ready_o
);

    localparam int SHIFT = 2 * `METER_LOG2;
    localparam int SUM_BITS = `PIXEL_BITS + SHIFT;

    typedef logic [SUM_BITS-1:0] sum_t;

    coord_t        column_q;        // Binned column of next pixel
    coord_t        row_q;           // Binned row
    logic          gap_q;           // Previous cycle had no pixel
    logic          frame_valid_q;
    logic          frame_end_q;
    logic          ready_q;
    logic          in_square;
    logic          frame_start;
    sum_t          red_sum_q;
    sum_t          green_sum_q;
    sum_t          blue_sum_q;
    raw_pixel_t    red_avg;
    raw_pixel_t    green_avg;
    raw_pixel_t    blue_avg;
    meter_result_t result_q;

    always_comb begin
        in_square = (column_q < `METER_SIZE) && (row_q < `METER_SIZE);
        frame_start = rgb_i.frame_valid && !frame_valid_q;
        red_avg = raw_pixel_t'(red_sum_q >> SHIFT);
        green_avg = raw_pixel_t'(green_sum_q >> SHIFT);
        blue_avg = raw_pixel_t'(blue_sum_q >> SHIFT);
    end

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            column_q <= '0;
            row_q <= '0;
            gap_q <= 1'b1;
            frame_valid_q <= 1'b0;
            frame_end_q <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            gap_q <= !rgb_i.valid;
            frame_valid_q <= rgb_i.frame_valid;
            frame_end_q <= frame_valid_q && !rgb_i.frame_valid;
            ready_q <= frame_end_q;

            // Pixels come every other cycle, two idle cycles end a line
            if (!rgb_i.frame_valid) begin
                column_q <= '0;
                row_q <= '0;
            end else if (rgb_i.valid) begin
                column_q <= column_q + 1'b1;
            end else if (gap_q && column_q != '0) begin
                column_q <= '0;
                row_q <= row_q + 1'b1;
            end
        end
    end

    always_ff @(posedge mipi_byte_clock) begin
        if (frame_start) begin
            red_sum_q <= '0;
            green_sum_q <= '0;
            blue_sum_q <= '0;
        end else if (rgb_i.valid && in_square) begin
            red_sum_q <= red_sum_q + rgb_i.red;
            green_sum_q <= green_sum_q + rgb_i.green;
            blue_sum_q <= blue_sum_q + rgb_i.blue;
        end

        if (frame_end_q) begin
            result_q.red <= red_avg[`PIXEL_BITS-1 -: 8];     // Top 8 bits
            result_q.green <= green_avg[`PIXEL_BITS-1 -: 8];
            result_q.blue <= blue_avg[`PIXEL_BITS-1 -: 8];
        end
    end

    assign result_o = result_q;
    assign ready_o = ready_q;

endmodule

`default_nettype wire

//--- bayer_binning.sv
// RGGB 2x2 binning
`timescale 1ns/1ps
`default_nettype none

`include "camera_defs.svh"

module bayer_binning import camera_pkg::*; (
    input  logic          mipi_byte_clock,
    input  logic          mipi_byte_reset_n,
    input  bayer_stream_t cropped_i,
    output rgb_stream_t   rgb_o
);

    localparam int ADDR_BITS = $clog2(`MAX_LINE_PIXELS);

    raw_pixel_t           line_buffer [`MAX_LINE_PIXELS];
    logic [ADDR_BITS-1:0] column_q;         // Cropped column of current beat
    logic                 row_odd_q;        // Cropped row parity
    logic                 line_valid_q;
    raw_pixel_t           stored;           // Even-row sample at this column
    raw_pixel_t           prev_sample_q;    // Previous sample on this row
    raw_pixel_t           red_hold_q;       // Even-row sample at previous column
    logic [`PIXEL_BITS:0] green_sum;
    logic                 emit;

    logic                 frame_valid_out_q;
    logic                 valid_out_q;
    raw_pixel_t           red_q;
    raw_pixel_t           green_q;
    raw_pixel_t           blue_q;

    always_comb begin
        stored = line_buffer[column_q];
        green_sum = stored + prev_sample_q;
        // Second beat of a quad on an odd row closes the quad
        emit = cropped_i.line_valid && row_odd_q && column_q[0];
    end

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            column_q <= '0;
            row_odd_q <= 1'b0;
            line_valid_q <= 1'b0;
        end else begin
            line_valid_q <= cropped_i.line_valid;

            if (cropped_i.line_valid) begin
                column_q <= column_q + 1'b1;
            end else begin
                column_q <= '0;
            end

            if (!cropped_i.frame_valid) begin
                row_odd_q <= 1'b0;
            end else if (line_valid_q && !cropped_i.line_valid) begin
                row_odd_q <= !row_odd_q;
            end
        end
    end

    // Line buffer holds the R/G row of each quad
    always_ff @(posedge mipi_byte_clock) begin
        if (cropped_i.line_valid && !row_odd_q) begin
            line_buffer[column_q] <= cropped_i.data;
        end
    end

    always_ff @(posedge mipi_byte_clock) begin
        if (cropped_i.line_valid) begin
            prev_sample_q <= cropped_i.data;
            red_hold_q <= stored;
        end
        if (emit) begin
            red_q <= red_hold_q;
            green_q <= green_sum[`PIXEL_BITS:1];    // Mean of both greens
            blue_q <= cropped_i.data;
        end
    end

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            frame_valid_out_q <= 1'b0;
            valid_out_q <= 1'b0;
        end else begin
            frame_valid_out_q <= cropped_i.frame_valid;
            valid_out_q <= emit;
        end
    end

    always_comb begin
        rgb_o.frame_valid = frame_valid_out_q;
        rgb_o.valid = valid_out_q;
        rgb_o.red = red_q;
        rgb_o.green = green_q;
        rgb_o.blue = blue_q;
    end

endmodule

`default_nettype wire

//--- bayer_crop.sv
// Bayer pan crop
`timescale 1ns/1ps
`default_nettype none

module bayer_crop import camera_pkg::*; (
    input  logic          mipi_byte_clock,
    input  logic          mipi_byte_reset_n,
    input  bayer_stream_t raw_i,
    input  crop_window_t  window_i,
    output bayer_stream_t cropped_o
);

    coord_t     column_q;           // Column of the current input beat
    coord_t     row_q;              // Row of the current input line
    logic       line_valid_q;       // For line end detection
    logic       in_window;
    logic       frame_valid_out_q;
    logic       line_valid_out_q;
    raw_pixel_t data_out_q;

    always_comb begin
        in_window = (column_q >= window_i.x_start) && (column_q < window_i.x_end) &&
                    (row_q >= window_i.y_start) && (row_q < window_i.y_end);
    end

    // Position counters
    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            column_q <= '0;
            row_q <= '0;
            line_valid_q <= 1'b0;
        end else begin
            line_valid_q <= raw_i.line_valid;

            if (raw_i.line_valid) begin
                column_q <= column_q + 1'b1;
            end else begin
                column_q <= '0;
            end

            if (!raw_i.frame_valid) begin
                row_q <= '0;
            end else if (line_valid_q && !raw_i.line_valid) begin
                row_q <= row_q + 1'b1;  // Advance at line end
            end
        end
    end

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            frame_valid_out_q <= 1'b0;
            line_valid_out_q <= 1'b0;
        end else begin
            frame_valid_out_q <= raw_i.frame_valid;
            line_valid_out_q <= raw_i.line_valid && in_window;
        end
    end

    always_ff @(posedge mipi_byte_clock) begin
        data_out_q <= raw_i.data;
    end

    always_comb begin
        cropped_o.frame_valid = frame_valid_out_q;
        cropped_o.line_valid = line_valid_out_q;
        cropped_o.data = data_out_q;
    end

endmodule

`default_nettype wire

//--- crop_window_regs.sv
// Crop window registers
`timescale 1ns/1ps
`default_nettype none

`include "camera_defs.svh"

module crop_window_regs import camera_pkg::*; (
    input  logic         mipi_byte_clock,
    input  logic         mipi_byte_reset_n,
    input  logic         cfg_write_i,
    input  cfg_addr_t    cfg_addr_i,
    input  coord_t       cfg_data_i,
    input  logic         frame_active_i,
    output crop_window_t window_o
);

    localparam crop_window_t RESET_WINDOW = '{
        x_start: coord_t'(`RESET_X_START),
        x_end:   coord_t'(`RESET_X_END),
        y_start: coord_t'(`RESET_Y_START),
        y_end:   coord_t'(`RESET_Y_END)
    };

    crop_window_t written_q;        // Last values written
    crop_window_t shadow_q;         // Values the crop stage sees
    coord_t       aligned_data;

    // Keep the window on RGGB quad boundaries
    always_comb aligned_data = {cfg_data_i[`COORD_BITS-1:1], 1'b0};

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            written_q <= RESET_WINDOW;
            shadow_q <= RESET_WINDOW;
        end else begin
            if (cfg_write_i) begin
                case (cfg_addr_i)
                    CFG_X_START: written_q.x_start <= aligned_data;
                    CFG_X_END:   written_q.x_end <= aligned_data;
                    CFG_Y_START: written_q.y_start <= aligned_data;
                    CFG_Y_END:   written_q.y_end <= aligned_data;
                    default:     written_q <= written_q;
                endcase
            end
            if (!frame_active_i) begin
                shadow_q <= written_q;   // Only between frames
            end
        end
    end

    assign window_o = shadow_q;

endmodule

`default_nettype wire

//--- camera_pkg.sv
// Camera front end types
`default_nettype none

`include "camera_defs.svh"

package camera_pkg;

    typedef logic [`PIXEL_BITS-1:0] raw_pixel_t;
    typedef logic [`COORD_BITS-1:0] coord_t;
    typedef logic [7:0] meter_value_t;
    typedef logic [1:0] cfg_addr_t;

    // Register indices for the crop window
    localparam cfg_addr_t CFG_X_START = 2'd0;
    localparam cfg_addr_t CFG_X_END = 2'd1;
    localparam cfg_addr_t CFG_Y_START = 2'd2;
    localparam cfg_addr_t CFG_Y_END = 2'd3;

    typedef struct packed {
        logic       frame_valid;
        logic       line_valid;
        raw_pixel_t data;
    } bayer_stream_t;

    typedef struct packed {
        logic       frame_valid;
        logic       valid;          // One binned pixel per beat
        raw_pixel_t red;
        raw_pixel_t green;
        raw_pixel_t blue;
    } rgb_stream_t;

    typedef struct packed {
        coord_t x_start;
        coord_t x_end;              // Exclusive
        coord_t y_start;
        coord_t y_end;              // Exclusive
    } crop_window_t;

    typedef struct packed {
        meter_value_t red;
        meter_value_t green;
        meter_value_t blue;
    } meter_result_t;

endpackage

`default_nettype wire

//--- camera_defs.svh
// Camera front end sizes
`ifndef CAMERA_DEFS_SVH
`define CAMERA_DEFS_SVH

// Raw Bayer sample and coordinate widths
`define PIXEL_BITS 10
`define COORD_BITS 11

// Depth of the even-row line buffer in the binning stage
`define MAX_LINE_PIXELS 64

// Crop window loaded at reset, quad aligned
`define RESET_X_START 2
`define RESET_X_END 34
`define RESET_Y_START 2
`define RESET_Y_END 18

// Metering square in binned pixels, side must be a power of two
`define METER_SIZE 8
`define METER_LOG2 3

`endif
